// File: Makefile
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_rv_pipeline \
		-f tb.f -Mdir $(BUILD) -o sim_tb
	./$(BUILD)/sim_tb

clean:
	rm -rf $(BUILD)

// File: bench/rv_pipeline_props.sv
`timescale 1ns/1ps

module rv_pipeline_props (
    input logic          CLK,
    input logic          RESET_N,
    input logic          CLEAR,
    input logic          mem_write,
    input logic          mem_read,
    input rv_pkg::word_t ddata_w
);
    // reset or clear in this cycle
    logic restart;

    assign restart = !RESET_N || CLEAR;

    // one data access per cycle
    no_dual_access: assert property (@(posedge CLK) !(mem_read && mem_write))
        else $error("mem_read and mem_write both high");

    // pipe stays empty three cycles after a restart
    quiet_after_restart: assert property (@(posedge CLK)
        (restart || $past(restart, 1) || $past(restart, 2) || $past(restart, 3))
        |-> !mem_read && !mem_write)
        else $error("data access during or just after a restart");

    store_data_known: assert property (@(posedge CLK) mem_write |-> !$isunknown(ddata_w))
        else $error("ddata_w unknown on a store");

endmodule

bind rv_pipeline rv_pipeline_props u_props (
    .CLK(CLK), .RESET_N(RESET_N), .CLEAR(CLEAR),
    .mem_write(mem_write), .mem_read(mem_read), .ddata_w(ddata_w)
);

// File: bench/tb_rv_pipeline.sv
`timescale 1ns/1ps

module tb_rv_pipeline;
    import rv_pkg::*;

    localparam int PROG_LEN = 64;
    localparam int SEED = 31695;
    localparam int WATCHDOG_CYCLES = 2 * PROG_LEN * 4 + 200;
    // instruction classes of the generator
    localparam int K_R = 0, K_I = 1, K_LUI = 2, K_LW = 3, K_SW = 4, K_BR = 5, K_JAL = 6;
    // {funct7, funct3} per model alu selector, add sub and or xor slt sltu sll srl sra
    localparam logic [9:0] FUNCT [10] = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004,
                                          10'h002, 10'h003, 10'h001, 10'h005, 10'h105};

    logic CLK, RESET_N, CLEAR, mem_write, mem_read;
    word_t idata, ddata_r, ddata_w;
    waddr_t iaddr, daddr;
    word_t imem [256];
    word_t dmem [256];
    word_t init_mem [256];
    word_t model_mem [256];
    // decoded program, the model runs from these fields
    int kind [PROG_LEN];
    int sel [PROG_LEN];
    int step [PROG_LEN];
    reg_idx_t rd_a [PROG_LEN];
    reg_idx_t rs1_a [PROG_LEN];
    reg_idx_t rs2_a [PROG_LEN];
    word_t imm_a [PROG_LEN];
    // expected store stream
    waddr_t exp_addr [$];
    word_t exp_data [$];
    int consumed;
    logic [31:0] lcg_state;

    rv_pipeline uut (.*);

    // both memories answer in the same cycle
    assign idata = imem[iaddr];
    // load data only under the read strobe, inverted word otherwise
    assign ddata_r = mem_read ? dmem[daddr] : ~dmem[daddr];

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        // high half moved down, low lcg bits are weak
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic int pick(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    function automatic reg_idx_t src_reg(input int i);
        reg_idx_t r;
        r = reg_idx_t'(1 + pick(8));
        // no interlocks, a recent destination would read stale
        if (r == rd_a[i-1] || r == rd_a[i-2] || r == rd_a[i-3]) begin
            r = '0;
        end
        return r;
    endfunction

    function automatic word_t model_alu(input int s, input word_t a, input word_t b);
        case (s)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return {31'b0, $signed(a) < $signed(b)};
            6: return {31'b0, a < b};
            7: return a << b[4:0];
            8: return a >> b[4:0];
            9: return $signed(a) >>> b[4:0];
            default: return a + b;
        endcase
    endfunction

    function automatic word_t encode(input int i);
        logic [9:0] f;
        word_t m;
        f = FUNCT[sel[i]];
        m = imm_a[i];
        case (kind[i])
            K_R:   return {f[9:3], rs2_a[i], rs1_a[i], f[2:0], rd_a[i], 7'b0110011};
            K_I:   return {m[11:0], rs1_a[i], f[2:0], rd_a[i], 7'b0010011};
            K_LUI: return {m[31:12], rd_a[i], 7'b0110111};
            K_LW:  return {m[11:0], 5'd0, 3'b010, rd_a[i], 7'b0000011};
            K_SW:  return {m[11:5], rs2_a[i], 5'd0, 3'b010, m[4:0], 7'b0100011};
            // funct3 000 beq, 001 bne
            K_BR:  return {m[12], m[10:5], rs2_a[i], rs1_a[i], 2'b00, sel[i][0],
                           m[4:1], m[11], 7'b1100011};
            default: return {m[20], m[10:1], m[11], m[19:12], rd_a[i], 7'b1101111};
        endcase
    endfunction

    task automatic gen_program();
        int t;
        word_t r;
        for (int i = 0; i < PROG_LEN; i++) begin
            // 9 seeds x1..x8, 10 is the closing self-loop
            t = (i < 8) ? 9 : (i == PROG_LEN - 1) ? 10 : pick(9);
            // transfers stay inside the program
            if (i > PROG_LEN - 7 && (t == 7 || t == 8)) begin
                t = 0;
            end
            r = next_rand();
            kind[i] = K_R;
            sel[i] = pick(10);
            step[i] = 2 + pick(4);
            rd_a[i] = reg_idx_t'(1 + pick(8));
            rs1_a[i] = (i < 8) ? '0 : src_reg(i);
            rs2_a[i] = (i < 8) ? '0 : src_reg(i);
            imm_a[i] = {{20{r[11]}}, r[11:0]};
            case (t)
                2: begin
                    kind[i] = K_I;
                    // addi andi ori xori slti sltiu
                    sel[i] = (sel[i] % 6 == 0) ? 0 : sel[i] % 6 + 1;
                end
                3: begin
                    kind[i] = K_LUI;
                    imm_a[i] = {r[31:12], 12'b0};
                end
                4: begin
                    kind[i] = K_LW;
                    rs1_a[i] = '0;
                    imm_a[i] = word_t'(pick(32) * 4);
                end
                5, 6: begin
                    kind[i] = K_SW;
                    rs1_a[i] = '0;
                    rd_a[i] = '0;
                    imm_a[i] = word_t'(pick(32) * 4);
                end
                7: begin
                    kind[i] = K_BR;
                    sel[i] = pick(2);
                    rd_a[i] = '0;
                    imm_a[i] = word_t'(step[i] * 4);
                end
                8: begin
                    kind[i] = K_JAL;
                    imm_a[i] = word_t'(step[i] * 4);
                end
                9: begin
                    kind[i] = K_I;
                    sel[i] = 0;
                    rd_a[i] = reg_idx_t'(i + 1);
                end
                10: begin
                    // beq x0,x0,0
                    kind[i] = K_BR;
                    sel[i] = 0;
                    rd_a[i] = '0;
                    rs1_a[i] = '0;
                    rs2_a[i] = '0;
                    imm_a[i] = '0;
                end
                default: ;
            endcase
            imem[i] = encode(i);
        end
        // opcode 0 past the end, decodes as a bubble
        for (int i = PROG_LEN; i < 256; i++) begin
            imem[i] = '0;
        end
    endtask

    // isa walk from pc 0, fills the expected store stream
    task automatic run_model();
        word_t r [32];
        int i;
        int nxt;
        word_t a;
        for (int k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        i = 0;
        // forward-only transfers, so the walk ends at the self-loop
        while (i < PROG_LEN - 1) begin
            nxt = i + 1;
            a = imm_a[i];
            case (kind[i])
                K_R:   r[rd_a[i]] = model_alu(sel[i], r[rs1_a[i]], r[rs2_a[i]]);
                K_I:   r[rd_a[i]] = model_alu(sel[i], r[rs1_a[i]], a);
                K_LUI: r[rd_a[i]] = a;
                K_LW:  r[rd_a[i]] = model_mem[a[9:2]];
                K_SW: begin
                    model_mem[a[9:2]] = r[rs2_a[i]];
                    exp_addr.push_back(a[9:2]);
                    exp_data.push_back(r[rs2_a[i]]);
                end
                K_BR: begin
                    if ((r[rs1_a[i]] == r[rs2_a[i]]) != sel[i][0]) begin
                        nxt = i + step[i];
                    end
                end
                default: begin
                    // link is the jump's own pc plus 4
                    r[rd_a[i]] = word_t'(4 * i + 4);
                    nxt = i + step[i];
                end
            endcase
            i = nxt;
        end
    endtask

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%08h actual=%08h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // data memory, preloaded while reset is low
    always @(posedge CLK) begin
        if (!RESET_N) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= init_mem[a];
            end
        end else if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    // every store checked in order
    always @(posedge CLK) begin
        if (mem_write) begin
            if (exp_addr.size() == 0) begin
                $display("store at time %0t with no store left to expect", $time);
                stop_run();
            end else begin
                check_value("daddr", word_t'(exp_addr[0]), word_t'(daddr));
                check_value("ddata_w", exp_data[0], ddata_w);
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                consumed++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout, the expected stores never completed");
        stop_run();
    end

    initial begin
        int half;
        RESET_N = 1'b0;
        CLEAR = 1'b0;
        consumed = 0;
        lcg_state = SEED;
        gen_program();
        for (int a = 0; a < 256; a++) begin
            init_mem[a] = next_rand();
            model_mem[a] = init_mem[a];
        end
        run_model();
        half = exp_addr.size() / 2;
        repeat (16) @(negedge CLK);
        RESET_N = 1'b1;
        check_value("iaddr", '0, word_t'(iaddr));
        while (consumed < half) @(negedge CLK);
        // one-cycle restart halfway through
        @(negedge CLK);
        CLEAR = 1'b1;
        @(negedge CLK);
        CLEAR = 1'b0;
        exp_addr.delete();
        exp_data.delete();
        for (int a = 0; a < 256; a++) begin
            model_mem[a] = dmem[a];
        end
        run_model();
        while (exp_addr.size() != 0) @(negedge CLK);
        // trailing cycles catch a stray store
        repeat (20) @(negedge CLK);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    input  rv_pkg::alu_op_t  op,
    output rv_pkg::word_t    result,
    output logic             zero
);
    import rv_pkg::*;

    // shift amount from low five bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = word_t'(a < b);
            ALU_SLL:    result = a << shamt;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            // lui immediate goes through untouched
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // equality test for beq and bne
    assign zero = (result == '0);

endmodule

// File: src/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  rv_pkg::word_t    inst,
    output logic             reg_write,
    output logic             mem_read,
    output logic             mem_write,
    output logic             branch,
    output logic             jump,
    output logic             alu_src_imm,
    output logic             branch_ne,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::wb_sel_t  wb_sel,
    output rv_pkg::word_t    imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];

    always_comb begin
        // defaults give a bubble for unknown opcodes
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        alu_src_imm = 1'b0;
        branch_ne   = 1'b0;
        alu_op      = ALU_ADD;
        wb_sel      = WB_ALU;
        // i-type immediate unless overridden below
        imm         = {{20{inst[31]}}, inst[31:20]};

        case (opcode)
            OP_R, OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = (opcode == OP_IMM);
                case (funct3)
                    // sub only for r-type, addi stays an add
                    3'b000:  alu_op = (opcode == OP_R && bit30) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    // bit 30 picks arithmetic shift in both forms
                    3'b101:  alu_op = bit30 ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OP_LOAD: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                // beq and bne only, compare by subtract
                branch    = (funct3[2:1] == 2'b00);
                branch_ne = funct3[0];
                alu_op    = ALU_SUB;
                imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            OP_JAL: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = WB_LINK;
                imm       = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = ALU_PASS_B;
                imm         = {inst[31:12], 12'b0};
            end
            default: ;
        endcase
    end

endmodule

// File: src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic         CLK,
    input  logic         RESET_N,
    input  logic         clear,
    input  logic         redirect,
    input  rv_pkg::pc_t  target,
    output rv_pkg::pc_t  pc
);
    import rv_pkg::*;

    // sequential step, one word per cycle
    localparam pc_t PC_STEP = pc_t'(4);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (clear) begin
            // restart wins over a taken transfer
            pc <= '0;
        end else if (redirect) begin
            // branch or jal resolved in memory stage
            pc <= target;
        end else begin
            pc <= pc + PC_STEP;
        end
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              CLK,
    input  logic              RESET_N,
    input  rv_pkg::reg_idx_t  rs1,
    input  rv_pkg::reg_idx_t  rs2,
    input  rv_pkg::reg_idx_t  rd,
    input  logic              wr_en,
    input  rv_pkg::word_t     wr_data,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2
);
    import rv_pkg::*;

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;
        end
    end

    // x0 reads zero, same-cycle write is passed through
    assign rd1 = (rs1 == '0) ? '0 : (wr_en && rd == rs1) ? wr_data : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (wr_en && rd == rs2) ? wr_data : regs[rs2];

endmodule

// File: src/rv_pipeline.sv
`timescale 1ns/1ps

module rv_pipeline (
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic            CLEAR,
    input  rv_pkg::word_t   idata,
    input  rv_pkg::word_t   ddata_r,
    output rv_pkg::waddr_t  iaddr,
    output rv_pkg::waddr_t  daddr,
    output rv_pkg::word_t   ddata_w,
    output logic            mem_write,
    output logic            mem_read
);
    import rv_pkg::*;

    localparam pc_t PC_STEP = pc_t'(4);

    pc_t      pc;
    logic     redirect, squash;
    // fetch/decode
    logic     id_valid;
    pc_t      id_pc;
    word_t    id_inst;
    // decode outputs
    logic     dec_reg_write, dec_mem_read, dec_mem_write, dec_branch, dec_jump;
    logic     dec_alu_src_imm, dec_branch_ne;
    alu_op_t  dec_alu_op;
    wb_sel_t  dec_wb_sel;
    word_t    dec_imm, id_rd1, id_rd2;
    // decode/execute
    logic     ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jump;
    logic     ex_alu_src_imm, ex_branch_ne, ex_zero;
    alu_op_t  ex_alu_op;
    wb_sel_t  ex_wb_sel;
    pc_t      ex_pc;
    reg_idx_t ex_rd;
    word_t    ex_rd1, ex_rd2, ex_imm, ex_alu_b, ex_alu_result;
    // execute/memory
    logic     ma_valid, ma_reg_write, ma_mem_read, ma_mem_write, ma_branch, ma_jump;
    logic     ma_branch_ne, ma_zero;
    wb_sel_t  ma_wb_sel;
    pc_t      ma_target, ma_link;
    reg_idx_t ma_rd;
    word_t    ma_alu_result, ma_store_data;
    // memory/writeback
    logic     wb_valid, wb_reg_write, wb_en;
    wb_sel_t  wb_src;
    pc_t      wb_link;
    reg_idx_t wb_rd;
    word_t    wb_alu_result, wb_load_data, wb_data;

    pc_unit u_pc (
        .CLK(CLK), .RESET_N(RESET_N), .clear(CLEAR),
        .redirect(redirect), .target(ma_target), .pc(pc)
    );

    assign iaddr = pc[ADDR_W-1:2];

    decoder u_dec (
        .inst(id_inst), .reg_write(dec_reg_write), .mem_read(dec_mem_read),
        .mem_write(dec_mem_write), .branch(dec_branch), .jump(dec_jump),
        .alu_src_imm(dec_alu_src_imm), .branch_ne(dec_branch_ne),
        .alu_op(dec_alu_op), .wb_sel(dec_wb_sel), .imm(dec_imm)
    );

    // write port driven from writeback
    reg_file u_rf (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(id_inst[19:15]), .rs2(id_inst[24:20]),
        .rd(wb_rd), .wr_en(wb_en), .wr_data(wb_data), .rd1(id_rd1), .rd2(id_rd2)
    );

    assign ex_alu_b = ex_alu_src_imm ? ex_imm : ex_rd2;

    alu u_alu (
        .a(ex_rd1), .b(ex_alu_b), .op(ex_alu_op), .result(ex_alu_result), .zero(ex_zero)
    );

    // taken transfer resolved in memory stage
    assign redirect = ma_valid & (ma_jump | (ma_branch & (ma_zero != ma_branch_ne)));
    // drop the three younger entries
    assign squash = redirect | CLEAR;

    // valid bits, restart empties every stage
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            ma_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            id_valid <= ~squash;
            ex_valid <= id_valid & ~squash;
            ma_valid <= ex_valid & ~squash;
            // the jump itself still retires its link
            wb_valid <= ma_valid & ~CLEAR;
        end
    end

    // stage payload, qualified by the valid bits
    always_ff @(posedge CLK) begin
        id_pc          <= pc;
        id_inst        <= idata;
        ex_pc          <= id_pc;
        ex_rd          <= id_inst[11:7];
        ex_rd1         <= id_rd1;
        ex_rd2         <= id_rd2;
        ex_imm         <= dec_imm;
        ex_reg_write   <= dec_reg_write;
        ex_mem_read    <= dec_mem_read;
        ex_mem_write   <= dec_mem_write;
        ex_branch      <= dec_branch;
        ex_jump        <= dec_jump;
        ex_alu_src_imm <= dec_alu_src_imm;
        ex_branch_ne   <= dec_branch_ne;
        ex_alu_op      <= dec_alu_op;
        ex_wb_sel      <= dec_wb_sel;
        // target and link from the transfer's own pc
        ma_target      <= ex_pc + ex_imm[ADDR_W-1:0];
        ma_link        <= ex_pc + PC_STEP;
        ma_rd          <= ex_rd;
        ma_alu_result  <= ex_alu_result;
        ma_zero        <= ex_zero;
        ma_store_data  <= ex_rd2;
        ma_reg_write   <= ex_reg_write;
        ma_mem_read    <= ex_mem_read;
        ma_mem_write   <= ex_mem_write;
        ma_branch      <= ex_branch;
        ma_jump        <= ex_jump;
        ma_branch_ne   <= ex_branch_ne;
        ma_wb_sel      <= ex_wb_sel;
        wb_rd          <= ma_rd;
        wb_reg_write   <= ma_reg_write;
        wb_src         <= ma_wb_sel;
        wb_link        <= ma_link;
        wb_alu_result  <= ma_alu_result;
        wb_load_data   <= ddata_r;
    end

    // data port, strobes held off during restart
    assign daddr     = ma_alu_result[ADDR_W-1:2];
    assign ddata_w   = ma_store_data;
    assign mem_write = ma_valid & ma_mem_write & ~CLEAR;
    assign mem_read  = ma_valid & ma_mem_read & ~CLEAR;

    // writeback select
    assign wb_en = wb_valid & wb_reg_write;

    always_comb begin
        case (wb_src)
            WB_MEM:  wb_data = wb_load_data;
            WB_LINK: wb_data = word_t'(wb_link);
            default: wb_data = wb_alu_result;
        endcase
    end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    // datapath and memory widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 10;

    // one data word on every port and in the register file
    typedef logic [DATA_W-1:0] word_t;
    // byte address held by the pc
    typedef logic [ADDR_W-1:0] pc_t;
    // word address seen by both memories
    typedef logic [ADDR_W-3:0] waddr_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] wb_sel_t;

    // alu operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    // operand b straight through, for lui
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // writeback sources
    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_MEM  = 2'd1;
    // own pc plus 4, for jal
    localparam wb_sel_t WB_LINK = 2'd2;

    // rv32i major opcodes, inst[6:0]
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

endpackage

// File: tb.f
src/rv_pkg.sv
src/pc_unit.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/rv_pipeline.sv
bench/rv_pipeline_props.sv
bench/tb_rv_pipeline.sv
